/* source/amber_sys_pkg.sv */
package amber_sys_pkg;

    // Bus widths are fixed for this system
    localparam int WB_DWIDTH = 32;
    localparam int WB_SWIDTH = 4;

    // --------------------
    // Wishbone bundles
    // --------------------
    typedef struct packed {
        logic [31:0]          adr;
        logic [WB_SWIDTH-1:0] sel;
        logic                 we;
        logic [WB_DWIDTH-1:0] dat;
        logic                 cyc;
        logic                 stb;
    } wb_req_t;

    typedef struct packed {
        logic [WB_DWIDTH-1:0] dat;
        logic                 ack;
        logic                 err;
    } wb_rsp_t;

    // Address map, from adr[31:28]
    typedef enum logic [3:0] {
        REGION_BOOT_MEM = 4'd0,
        REGION_TEST     = 4'd1,
        REGION_TIMER    = 4'd2,
        REGION_IRQ_CTRL = 4'd3
    } wb_region_e;

    // --------------------
    // Register offsets
    // --------------------
    // Timer, from adr[3:2]
    typedef enum logic [1:0] {
        TM_LOAD  = 2'd0,
        TM_VALUE = 2'd1,
        TM_CTRL  = 2'd2,
        TM_CLEAR = 2'd3
    } timer_reg_e;

    // Interrupt controller, from adr[4:2]
    typedef enum logic [2:0] {
        IC_IRQ_STATUS        = 3'd0,
        IC_RAW_STATUS        = 3'd1,
        IC_IRQ_ENABLE_SET    = 3'd2,
        IC_IRQ_ENABLE_CLEAR  = 3'd3,
        IC_FIRQ_STATUS       = 3'd4,
        IC_FIRQ_ENABLE_SET   = 3'd5,
        IC_FIRQ_ENABLE_CLEAR = 3'd6
    } ic_reg_e;

    // Test module, from adr[3:2]
    typedef enum logic [1:0] {
        TEST_IRQ    = 2'd0,
        TEST_FIRQ   = 2'd1,
        TEST_STATUS = 2'd2
    } test_reg_e;

    // Interrupt source bit positions
    localparam int IRQ_SRC_TEST_IRQ  = 0;
    localparam int IRQ_SRC_TEST_FIRQ = 1;
    localparam int IRQ_SRC_TIMER     = 2;
    localparam int NUM_IRQ_SRC       = 3;

endpackage

/* source/wb_decoder.sv */
`timescale 1ns/1ns

module wb_decoder
    import amber_sys_pkg::*;
(
    input  logic    i_sys_clk,
    input  logic    i_rst_n,
    input  wb_req_t i_wb_req,
    output wb_rsp_t o_wb_rsp,
    output wb_req_t o_boot_req,
    output wb_req_t o_test_req,
    output wb_req_t o_timer_req,
    output wb_req_t o_ic_req,
    input  wb_rsp_t i_boot_rsp,
    input  wb_rsp_t i_test_rsp,
    input  wb_rsp_t i_timer_rsp,
    input  wb_rsp_t i_ic_rsp
);

    wb_region_e region;
    logic       unmapped;
    logic       err_q;

    assign region   = wb_region_e'(i_wb_req.adr[31:28]);
    assign unmapped = (region != REGION_BOOT_MEM) && (region != REGION_TEST) &&
                      (region != REGION_TIMER) && (region != REGION_IRQ_CTRL);

    // --------------------
    // Request routing
    // --------------------
    // Every slave sees the address and data, only the selected one sees cyc and stb
    always_comb begin
        o_boot_req      = i_wb_req;
        o_test_req      = i_wb_req;
        o_timer_req     = i_wb_req;
        o_ic_req        = i_wb_req;
        o_boot_req.cyc  = i_wb_req.cyc && (region == REGION_BOOT_MEM);
        o_boot_req.stb  = i_wb_req.stb && (region == REGION_BOOT_MEM);
        o_test_req.cyc  = i_wb_req.cyc && (region == REGION_TEST);
        o_test_req.stb  = i_wb_req.stb && (region == REGION_TEST);
        o_timer_req.cyc = i_wb_req.cyc && (region == REGION_TIMER);
        o_timer_req.stb = i_wb_req.stb && (region == REGION_TIMER);
        o_ic_req.cyc    = i_wb_req.cyc && (region == REGION_IRQ_CTRL);
        o_ic_req.stb    = i_wb_req.stb && (region == REGION_IRQ_CTRL);
    end

    // Bus error for holes in the map, same latency as a slave ack
    always_ff @(posedge i_sys_clk) begin
        if (!i_rst_n) begin
            err_q <= 1'b0;
        end else begin
            err_q <= i_wb_req.cyc && i_wb_req.stb && unmapped && !err_q;
        end
    end

    // --------------------
    // Response return
    // --------------------
    always_comb begin
        case (region)
            REGION_BOOT_MEM: o_wb_rsp = i_boot_rsp;
            REGION_TEST:     o_wb_rsp = i_test_rsp;
            REGION_TIMER:    o_wb_rsp = i_timer_rsp;
            REGION_IRQ_CTRL: o_wb_rsp = i_ic_rsp;
            default: begin
                o_wb_rsp     = '0;
                o_wb_rsp.err = err_q;
            end
        endcase
    end

endmodule

/* source/boot_mem.sv */
`timescale 1ns/1ns

module boot_mem
    import amber_sys_pkg::*;
#(
    parameter int BOOT_WORDS = 2048
) (
    input  logic    i_sys_clk,
    input  logic    i_rst_n,
    input  wb_req_t i_wb_req,
    output wb_rsp_t o_wb_rsp
);

    localparam int ADDR_W = $clog2(BOOT_WORDS);

    logic [WB_DWIDTH-1:0] mem [BOOT_WORDS];
    logic [WB_DWIDTH-1:0] rdata_q;
    logic [ADDR_W-1:0]    word_idx;
    logic                 live;
    logic                 ack_q;

    // Word index, upper address bits wrap around the array
    assign word_idx = i_wb_req.adr[ADDR_W+1:2];
    assign live     = i_wb_req.cyc && i_wb_req.stb && !ack_q;

    always_ff @(posedge i_sys_clk) begin
        if (!i_rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= live;
        end
    end

    // Byte lane writes and registered read data
    always_ff @(posedge i_sys_clk) begin
        if (live && i_wb_req.we) begin
            for (int i = 0; i < WB_SWIDTH; i++) begin
                if (i_wb_req.sel[i]) begin
                    mem[word_idx][i*8 +: 8] <= i_wb_req.dat[i*8 +: 8];
                end
            end
        end
        rdata_q <= mem[word_idx];
    end

    assign o_wb_rsp.dat = rdata_q;
    assign o_wb_rsp.ack = ack_q;
    assign o_wb_rsp.err = 1'b0;

endmodule

/* source/timer_module.sv */
`timescale 1ns/1ns

module timer_module
    import amber_sys_pkg::*;
(
    input  logic    i_sys_clk,
    input  logic    i_rst_n,
    input  wb_req_t i_wb_req,
    output wb_rsp_t o_wb_rsp,
    output logic    o_timer_int
);

    timer_reg_e           reg_sel;
    logic                 live;
    logic                 wr_en;
    logic                 ack_q;
    logic [WB_DWIDTH-1:0] rdata;
    logic [WB_DWIDTH-1:0] rdata_q;
    logic [WB_DWIDTH-1:0] load_q;
    logic [WB_DWIDTH-1:0] value_q;
    logic                 enable_q;
    logic                 periodic_q;
    logic                 flag_q;

    assign reg_sel = timer_reg_e'(i_wb_req.adr[3:2]);
    assign live    = i_wb_req.cyc && i_wb_req.stb && !ack_q;
    assign wr_en   = live && i_wb_req.we;

    // --------------------
    // Registers and counter
    // --------------------
    always_ff @(posedge i_sys_clk) begin
        if (!i_rst_n) begin
            ack_q      <= 1'b0;
            load_q     <= '0;
            value_q    <= '0;
            enable_q   <= 1'b0;
            periodic_q <= 1'b0;
            flag_q     <= 1'b0;
        end else begin
            ack_q <= live;
            if (wr_en && reg_sel == TM_LOAD) begin
                load_q <= i_wb_req.dat;
            end
            if (wr_en && reg_sel == TM_CLEAR) begin
                flag_q <= 1'b0;
            end
            if (wr_en && reg_sel == TM_CTRL) begin
                enable_q   <= i_wb_req.dat[0];
                periodic_q <= i_wb_req.dat[1];
                // Start from the load value when enabled
                if (i_wb_req.dat[0]) begin
                    value_q <= load_q;
                end
            end else if (enable_q && value_q != '0) begin
                if (value_q == WB_DWIDTH'(1)) begin
                    // Expiry, reload in periodic mode, else hold at zero
                    flag_q  <= 1'b1;
                    value_q <= periodic_q ? load_q : '0;
                end else begin
                    value_q <= value_q - 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (reg_sel)
            TM_LOAD:  rdata = load_q;
            TM_VALUE: rdata = value_q;
            TM_CTRL:  rdata = WB_DWIDTH'({periodic_q, enable_q});
            default:  rdata = WB_DWIDTH'(flag_q);
        endcase
    end

    always_ff @(posedge i_sys_clk) begin
        rdata_q <= rdata;
    end

    assign o_wb_rsp.dat = rdata_q;
    assign o_wb_rsp.ack = ack_q;
    assign o_wb_rsp.err = 1'b0;
    assign o_timer_int  = flag_q;

endmodule

/* source/interrupt_controller.sv */
`timescale 1ns/1ns

module interrupt_controller
    import amber_sys_pkg::*;
(
    input  logic                   i_sys_clk,
    input  logic                   i_rst_n,
    input  wb_req_t                i_wb_req,
    output wb_rsp_t                o_wb_rsp,
    input  logic [NUM_IRQ_SRC-1:0] i_irq_src,
    output logic                   o_irq,
    output logic                   o_firq
);

    ic_reg_e                reg_sel;
    logic                   live;
    logic                   wr_en;
    logic                   ack_q;
    logic [NUM_IRQ_SRC-1:0] wr_bits;
    logic [NUM_IRQ_SRC-1:0] irq_mask_q;
    logic [NUM_IRQ_SRC-1:0] firq_mask_q;
    logic [NUM_IRQ_SRC-1:0] irq_status;
    logic [NUM_IRQ_SRC-1:0] firq_status;
    logic [WB_DWIDTH-1:0]   rdata;
    logic [WB_DWIDTH-1:0]   rdata_q;

    assign reg_sel = ic_reg_e'(i_wb_req.adr[4:2]);
    assign live    = i_wb_req.cyc && i_wb_req.stb && !ack_q;
    assign wr_en   = live && i_wb_req.we;
    assign wr_bits = i_wb_req.dat[NUM_IRQ_SRC-1:0];

    // Masked sources per processor line
    assign irq_status  = i_irq_src & irq_mask_q;
    assign firq_status = i_irq_src & firq_mask_q;

    always_ff @(posedge i_sys_clk) begin
        if (!i_rst_n) begin
            ack_q       <= 1'b0;
            irq_mask_q  <= '0;
            firq_mask_q <= '0;
        end else begin
            ack_q <= live;
            if (wr_en) begin
                case (reg_sel)
                    IC_IRQ_ENABLE_SET:    irq_mask_q  <= irq_mask_q | wr_bits;
                    IC_IRQ_ENABLE_CLEAR:  irq_mask_q  <= irq_mask_q & ~wr_bits;
                    IC_FIRQ_ENABLE_SET:   firq_mask_q <= firq_mask_q | wr_bits;
                    IC_FIRQ_ENABLE_CLEAR: firq_mask_q <= firq_mask_q & ~wr_bits;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (reg_sel)
            IC_IRQ_STATUS:                         rdata = WB_DWIDTH'(irq_status);
            IC_RAW_STATUS:                         rdata = WB_DWIDTH'(i_irq_src);
            IC_FIRQ_STATUS:                        rdata = WB_DWIDTH'(firq_status);
            IC_IRQ_ENABLE_SET, IC_IRQ_ENABLE_CLEAR: rdata = WB_DWIDTH'(irq_mask_q);
            default:                               rdata = WB_DWIDTH'(firq_mask_q);
        endcase
    end

    always_ff @(posedge i_sys_clk) begin
        rdata_q <= rdata;
    end

    assign o_wb_rsp.dat = rdata_q;
    assign o_wb_rsp.ack = ack_q;
    assign o_wb_rsp.err = 1'b0;
    assign o_irq        = |irq_status;
    assign o_firq       = |firq_status;

endmodule

/* source/test_module.sv */
`timescale 1ns/1ns

module test_module
    import amber_sys_pkg::*;
(
    input  logic    i_sys_clk,
    input  logic    i_rst_n,
    input  wb_req_t i_wb_req,
    output wb_rsp_t o_wb_rsp,
    output logic    o_test_irq,
    output logic    o_test_firq
);

    test_reg_e            reg_sel;
    logic                 live;
    logic                 wr_en;
    logic                 ack_q;
    logic                 irq_q;
    logic                 firq_q;
    logic [WB_DWIDTH-1:0] status_q;
    logic [WB_DWIDTH-1:0] rdata;
    logic [WB_DWIDTH-1:0] rdata_q;

    assign reg_sel = test_reg_e'(i_wb_req.adr[3:2]);
    assign live    = i_wb_req.cyc && i_wb_req.stb && !ack_q;
    assign wr_en   = live && i_wb_req.we;

    // Software driven interrupt levels and status word
    always_ff @(posedge i_sys_clk) begin
        if (!i_rst_n) begin
            ack_q    <= 1'b0;
            irq_q    <= 1'b0;
            firq_q   <= 1'b0;
            status_q <= '0;
        end else begin
            ack_q <= live;
            if (wr_en) begin
                case (reg_sel)
                    TEST_IRQ:    irq_q    <= i_wb_req.dat[0];
                    TEST_FIRQ:   firq_q   <= i_wb_req.dat[0];
                    TEST_STATUS: status_q <= i_wb_req.dat;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (reg_sel)
            TEST_IRQ:    rdata = WB_DWIDTH'(irq_q);
            TEST_FIRQ:   rdata = WB_DWIDTH'(firq_q);
            TEST_STATUS: rdata = status_q;
            default:     rdata = '0;
        endcase
    end

    always_ff @(posedge i_sys_clk) begin
        rdata_q <= rdata;
    end

    assign o_wb_rsp.dat = rdata_q;
    assign o_wb_rsp.ack = ack_q;
    assign o_wb_rsp.err = 1'b0;
    assign o_test_irq   = irq_q;
    assign o_test_firq  = firq_q;

endmodule

/* source/amber_system.sv */
`timescale 1ns/1ns

module amber_system
    import amber_sys_pkg::*;
#(
    // 8 KB of boot SRAM
    parameter int BOOT_WORDS = 2048
) (
    input  logic    i_sys_clk,
    input  logic    i_rst_n,
    input  wb_req_t i_wb_req,
    output wb_rsp_t o_wb_rsp,
    output logic    o_irq,
    output logic    o_firq
);

    wb_req_t                boot_req;
    wb_req_t                test_req;
    wb_req_t                timer_req;
    wb_req_t                ic_req;
    wb_rsp_t                boot_rsp;
    wb_rsp_t                test_rsp;
    wb_rsp_t                timer_rsp;
    wb_rsp_t                ic_rsp;
    logic                   test_irq;
    logic                   test_firq;
    logic                   timer_int;
    logic [NUM_IRQ_SRC-1:0] irq_src;

    // Interrupt sources in controller bit order
    assign irq_src[IRQ_SRC_TEST_IRQ]  = test_irq;
    assign irq_src[IRQ_SRC_TEST_FIRQ] = test_firq;
    assign irq_src[IRQ_SRC_TIMER]     = timer_int;

    // --------------------
    // Address decoder
    // --------------------
    wb_decoder u_wb_decoder (
        .i_sys_clk   ( i_sys_clk ),
        .i_rst_n     ( i_rst_n   ),
        .i_wb_req    ( i_wb_req  ),
        .o_wb_rsp    ( o_wb_rsp  ),
        .o_boot_req  ( boot_req  ),
        .o_test_req  ( test_req  ),
        .o_timer_req ( timer_req ),
        .o_ic_req    ( ic_req    ),
        .i_boot_rsp  ( boot_rsp  ),
        .i_test_rsp  ( test_rsp  ),
        .i_timer_rsp ( timer_rsp ),
        .i_ic_rsp    ( ic_rsp    )
    );

    // --------------------
    // Slaves
    // --------------------
    boot_mem #(
        .BOOT_WORDS ( BOOT_WORDS )
    ) u_boot_mem (
        .i_sys_clk ( i_sys_clk ),
        .i_rst_n   ( i_rst_n   ),
        .i_wb_req  ( boot_req  ),
        .o_wb_rsp  ( boot_rsp  )
    );

    test_module u_test_module (
        .i_sys_clk   ( i_sys_clk ),
        .i_rst_n     ( i_rst_n   ),
        .i_wb_req    ( test_req  ),
        .o_wb_rsp    ( test_rsp  ),
        .o_test_irq  ( test_irq  ),
        .o_test_firq ( test_firq )
    );

    timer_module u_timer_module (
        .i_sys_clk   ( i_sys_clk ),
        .i_rst_n     ( i_rst_n   ),
        .i_wb_req    ( timer_req ),
        .o_wb_rsp    ( timer_rsp ),
        .o_timer_int ( timer_int )
    );

    interrupt_controller u_interrupt_controller (
        .i_sys_clk ( i_sys_clk ),
        .i_rst_n   ( i_rst_n   ),
        .i_wb_req  ( ic_req    ),
        .o_wb_rsp  ( ic_rsp    ),
        .i_irq_src ( irq_src   ),
        .o_irq     ( o_irq     ),
        .o_firq    ( o_firq    )
    );

endmodule

/* tb/amber_system_sva.sv */
`timescale 1ns/1ns

module amber_system_sva
    import amber_sys_pkg::*;
(
    input logic    i_sys_clk,
    input logic    i_rst_n,
    input wb_req_t i_wb_req,
    input wb_rsp_t o_wb_rsp
);

    logic resp;
    logic live;

    assign resp = o_wb_rsp.ack || o_wb_rsp.err;
    assign live = i_wb_req.cyc && i_wb_req.stb;

    // --------------------
    // Bus protocol
    // --------------------
    ack_err_exclusive: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
        !(o_wb_rsp.ack && o_wb_rsp.err))
        else $error("ack and err high in the same cycle");

    single_cycle_resp: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
        resp |=> !resp)
        else $error("response held for more than one cycle");

    // Answer only to a request seen on the previous edge
    resp_after_live: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
        resp |-> $past(live))
        else $error("response without a live request one cycle before");

endmodule

bind amber_system amber_system_sva u_amber_system_sva (
    .i_sys_clk ( i_sys_clk ),
    .i_rst_n   ( i_rst_n   ),
    .i_wb_req  ( i_wb_req  ),
    .o_wb_rsp  ( o_wb_rsp  )
);

/* tb/tb_amber_system.sv */
`timescale 1ns/1ns

module tb_amber_system
    import amber_sys_pkg::*;
();

    localparam int          BOOT_WIN    = 64;
    localparam logic [31:0] BOOT_BASE   = 32'h0000_0400;
    localparam int          BUS_TIMEOUT = 16;
    localparam int          POLL_LIMIT  = 100;

    logic    clk;
    logic    rst_n;
    wb_req_t req;
    wb_rsp_t rsp;
    logic    irq;
    logic    firq;

    // Reference state
    logic [31:0]            boot_model [BOOT_WIN];
    logic [NUM_IRQ_SRC-1:0] irq_mask;
    logic [NUM_IRQ_SRC-1:0] firq_mask;
    logic                   test_irq;
    logic                   test_firq;

    amber_system #(
        .BOOT_WORDS ( 2048 )
    ) dut (
        .i_sys_clk ( clk   ),
        .i_rst_n   ( rst_n ),
        .i_wb_req  ( req   ),
        .o_wb_rsp  ( rsp   ),
        .o_irq     ( irq   ),
        .o_firq    ( firq  )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("Verification failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    function automatic logic [31:0] reg_adr(input logic [3:0] region, input int offset);
        return {region, 28'(offset * 4)};
    endfunction

    function automatic logic [31:0] byte_mask(input logic [3:0] sel);
        return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    endfunction

    // One classic cycle that is called and returns 1 ns after a rising edge
    task automatic bus_access(input logic [31:0] adr, input logic we, input logic [3:0] sel,
                              input logic [31:0] wdat, output wb_rsp_t r);
        int waited;
        waited = 0;
        // One idle cycle between accesses
        @(posedge clk);
        #1;
        req.adr = adr;
        req.we  = we;
        req.sel = sel;
        req.dat = wdat;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        @(posedge clk);
        #1;
        while (!(rsp.ack || rsp.err)) begin
            if (waited >= BUS_TIMEOUT) begin
                $display("No ack or err came back for address 0x%08h", adr);
                $display("Verification failed");
                $fatal(1, "Bus timeout");
            end
            waited++;
            @(posedge clk);
            #1;
        end
        r = rsp;
        // Request stays up through the response cycle
        @(posedge clk);
        #1;
        req.cyc = 1'b0;
        req.stb = 1'b0;
        req.we  = 1'b0;
    endtask

    task automatic write_word(input logic [31:0] adr, input logic [3:0] sel,
                              input logic [31:0] wdat);
        wb_rsp_t r;
        bus_access(adr, 1'b1, sel, wdat, r);
        check_value("o_wb_rsp.ack", 32'(r.ack), 32'd1);
        check_value("o_wb_rsp.err", 32'(r.err), 32'd0);
    endtask

    task automatic read_word(input logic [31:0] adr, output logic [31:0] rdat);
        wb_rsp_t r;
        bus_access(adr, 1'b0, 4'hf, 32'h0, r);
        check_value("o_wb_rsp.ack", 32'(r.ack), 32'd1);
        check_value("o_wb_rsp.err", 32'(r.err), 32'd0);
        rdat = r.dat;
    endtask

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        int                     idx;
        int                     op;
        int                     polls;
        logic [31:0]            data;
        logic [31:0]            got;
        logic [31:0]            mask;
        logic [3:0]             sel;
        logic [NUM_IRQ_SRC-1:0] raw;
        wb_rsp_t                r;

        void'($urandom(32'h5f23));
        rst_n     = 1'b0;
        req       = '0;
        irq_mask  = '0;
        firq_mask = '0;
        test_irq  = 1'b0;
        test_firq = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("o_irq", 32'(irq), 32'd0);
        check_value("o_firq", 32'(firq), 32'd0);
        check_value("o_wb_rsp.ack", 32'(rsp.ack), 32'd0);
        check_value("o_wb_rsp.err", 32'(rsp.err), 32'd0);

        // Fill the boot memory window before mixing byte writes and reads
        for (int i = 0; i < BOOT_WIN; i++) begin
            data = $urandom;
            write_word(BOOT_BASE + 32'(i * 4), 4'hf, data);
            boot_model[i] = data;
        end
        repeat (200) begin
            idx = int'($urandom_range(BOOT_WIN - 1, 0));
            if ($urandom_range(1, 0) == 1) begin
                data = $urandom;
                sel  = 4'($urandom);
                mask = byte_mask(sel);
                write_word(BOOT_BASE + 32'(idx * 4), sel, data);
                boot_model[idx] = (boot_model[idx] & ~mask) | (data & mask);
            end else begin
                read_word(BOOT_BASE + 32'(idx * 4), got);
                check_value("boot_mem read data", got, boot_model[idx]);
            end
        end

        // Holes in the address map
        repeat (20) begin
            data = {4'(4 + $urandom_range(11, 0)), 28'($urandom)};
            bus_access(data, 1'($urandom), 4'hf, $urandom, r);
            check_value("o_wb_rsp.err", 32'(r.err), 32'd1);
            check_value("o_wb_rsp.ack", 32'(r.ack), 32'd0);
            check_value("o_wb_rsp.dat", r.dat, 32'd0);
        end

        repeat (20) begin
            data = $urandom;
            write_word(reg_adr(REGION_TEST, TEST_STATUS), 4'hf, data);
            read_word(reg_adr(REGION_TEST, TEST_STATUS), got);
            check_value("TEST_STATUS", got, data);
        end

        // Interrupt masks against software driven sources
        repeat (60) begin
            op   = int'($urandom_range(5, 0));
            data = $urandom;
            case (op)
                0: begin
                    write_word(reg_adr(REGION_TEST, TEST_IRQ), 4'hf, data);
                    test_irq = data[0];
                end
                1: begin
                    write_word(reg_adr(REGION_TEST, TEST_FIRQ), 4'hf, data);
                    test_firq = data[0];
                end
                2: begin
                    write_word(reg_adr(REGION_IRQ_CTRL, IC_IRQ_ENABLE_SET), 4'hf, data);
                    irq_mask = irq_mask | data[NUM_IRQ_SRC-1:0];
                end
                3: begin
                    write_word(reg_adr(REGION_IRQ_CTRL, IC_IRQ_ENABLE_CLEAR), 4'hf, data);
                    irq_mask = irq_mask & ~data[NUM_IRQ_SRC-1:0];
                end
                4: begin
                    write_word(reg_adr(REGION_IRQ_CTRL, IC_FIRQ_ENABLE_SET), 4'hf, data);
                    firq_mask = firq_mask | data[NUM_IRQ_SRC-1:0];
                end
                default: begin
                    write_word(reg_adr(REGION_IRQ_CTRL, IC_FIRQ_ENABLE_CLEAR), 4'hf, data);
                    firq_mask = firq_mask & ~data[NUM_IRQ_SRC-1:0];
                end
            endcase
            raw                    = '0;
            raw[IRQ_SRC_TEST_IRQ]  = test_irq;
            raw[IRQ_SRC_TEST_FIRQ] = test_firq;
            check_value("o_irq", 32'(irq), 32'(|(raw & irq_mask)));
            check_value("o_firq", 32'(firq), 32'(|(raw & firq_mask)));
            read_word(reg_adr(REGION_IRQ_CTRL, IC_RAW_STATUS), got);
            check_value("IC_RAW_STATUS", got, 32'(raw));
            read_word(reg_adr(REGION_IRQ_CTRL, IC_IRQ_STATUS), got);
            check_value("IC_IRQ_STATUS", got, 32'(raw & irq_mask));
            read_word(reg_adr(REGION_IRQ_CTRL, IC_FIRQ_STATUS), got);
            check_value("IC_FIRQ_STATUS", got, 32'(raw & firq_mask));
        end

        // Timer one-shot run
        data = 32'(5 + $urandom_range(35, 0));
        write_word(reg_adr(REGION_TIMER, TM_LOAD), 4'hf, data);
        write_word(reg_adr(REGION_TIMER, TM_CTRL), 4'hf, 32'h1);
        polls = 0;
        read_word(reg_adr(REGION_IRQ_CTRL, IC_RAW_STATUS), got);
        while (!got[IRQ_SRC_TIMER]) begin
            if (polls >= POLL_LIMIT) begin
                $display("Timer interrupt never showed in the raw status");
                $display("Verification failed");
                $fatal(1, "Timer timeout");
            end
            polls++;
            read_word(reg_adr(REGION_IRQ_CTRL, IC_RAW_STATUS), got);
        end
        read_word(reg_adr(REGION_TIMER, TM_VALUE), got);
        check_value("TM_VALUE", got, 32'd0);
        write_word(reg_adr(REGION_TIMER, TM_CLEAR), 4'hf, 32'h1);
        read_word(reg_adr(REGION_IRQ_CTRL, IC_RAW_STATUS), got);
        check_value("IC_RAW_STATUS timer bit", 32'(got[IRQ_SRC_TIMER]), 32'd0);

        $display("Verification passed");
        $finish;
    end

endmodule

/* compile.f */
source/amber_sys_pkg.sv
source/wb_decoder.sv
source/boot_mem.sv
source/timer_module.sv
source/interrupt_controller.sv
source/test_module.sv
source/amber_system.sv
tb/amber_system_sva.sv
tb/tb_amber_system.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_amber_system -f compile.f -o sim_amber_system

out=$(./obj_dir/sim_amber_system)
echo "$out"
echo "$out" | grep -q "Verification passed"
